// ==== build.f ====
logic/debug_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/debug_unit.sv
logic/mini_core.sv
logic/debug_system.sv
verification/tb_debug_system.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_debug_system
SEED      ?= 48082
OBJ_DIR   ?= obj_dir
FLIST     ?= build.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only if the simulation printed the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_debug_system.sv ====
`timescale 1ns/1ns

module tb_debug_system import debug_pkg::*; #(parameter int SEED = 32'hbbd2);

    localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT;
    localparam int FIXED_LEN   = 7;  // Fixed program incl. HALT
    // Bytes on the wire per test, commands and replies
    localparam int TEST_BYTES  = 22 + 20 + 121 + (66 + FIXED_LEN * 53 + 5) + 228 + 3 * 121;
    localparam int WATCHDOG_NS = TEST_BYTES * BYTE_CYCLES * 20 * 2;

    logic clock;
    logic reset;
    logic rx_serial;
    logic tx_serial;
    logic halted;
    logic monitor_on;
    logic rx_busy;
    logic [7:0] rx_q [$];

    // Reference model state
    logic [31:0] prog [IM_BYTES / 4];
    logic [31:0] m_regs [RB_REGS];
    logic [7:0]  m_dm [DM_BYTES];
    logic [31:0] m_pc;
    logic        m_halted;

    debug_system i_debug_system (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_rx_serial (rx_serial),
        .o_tx_serial (tx_serial),
        .o_halted    (halted)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run($sformatf("Run timed out after %0d ns", WATCHDOG_NS));
    end

    // Decodes reply bytes into rx_q, sampling at mid-bit
    initial begin : serial_monitor
        logic [7:0] data;
        rx_busy = 1'b0;
        forever begin
            @(negedge clock);
            if (monitor_on === 1'b1 && tx_serial === 1'b0) begin
                rx_busy = 1'b1;
                repeat (CLKS_PER_BIT / 2) @(negedge clock);
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    data[b] = tx_serial;
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                if (tx_serial !== 1'b1) begin
                    abort_run("Reply byte from the DUT has no stop bit");
                end else begin
                    rx_q.push_back(data);
                    rx_busy = 1'b0;
                end
            end
        end
    end

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};  // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            rx_serial <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
    endtask

    task automatic get_byte(input string name, output logic [7:0] value);
        int waited;
        waited = 0;
        while (rx_q.size() == 0) begin
            @(negedge clock);
            waited++;
            if (waited >= 4 * BYTE_CYCLES && !rx_busy) begin
                abort_run($sformatf("No reply from the DUT in %s", name));
            end
        end
        value = rx_q.pop_front();
    endtask

    task automatic expect_silence(input string name);
        repeat (4 * BYTE_CYCLES) @(negedge clock);
        if (rx_busy || rx_q.size() != 0) begin
            abort_run($sformatf("DUT replied to an ignored command in %s", name));
        end
    endtask

    task automatic wait_halted(input string name);
        int waited;
        waited = 0;
        while (halted !== 1'b1) begin
            @(negedge clock);
            waited++;
            if (waited > 4 * IM_BYTES) begin
                abort_run($sformatf("Core never halted in %s", name));
            end
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_status(input string name, input core_status_t exp,
                                  input core_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected halted %0b pc %h, actual halted %0b pc %h",
                                name, exp.halted, exp.pc, act.halted, act.pc));
        end
    endtask

    function automatic logic [31:0] encode_instr(input logic [7:0] op, input logic [2:0] rd,
                                                 input logic [2:0] rs, input logic [15:0] imm);
        return {op, 1'b0, rd, 1'b0, rs, imm};
    endfunction

    // Unused slots hold HALT, low bits tagged with the slot number
    task automatic fill_halts();
        for (int i = 0; i < IM_BYTES / 4; i++) begin
            prog[i] = {OP_HALT, 24'(i)};
        end
    endtask

    task automatic set_fixed_program();
        fill_halts();
        prog[0] = encode_instr(OP_ADDI, 3'd1, 3'd0, 16'd5);
        prog[1] = encode_instr(OP_ADDI, 3'd2, 3'd0, 16'hfffd);  // -3
        prog[2] = encode_instr(OP_ADD, 3'd3, 3'd1, {1'b0, 3'd2, 12'h000});
        prog[3] = encode_instr(OP_SB, 3'd0, 3'd3, 16'h0007);
        prog[4] = encode_instr(OP_ADD, 3'd4, 3'd3, {1'b0, 3'd1, 12'h000});
        prog[5] = encode_instr(OP_SB, 3'd0, 3'd4, 16'h000a);
    endtask

    task automatic set_random_program();
        int         len;
        logic [7:0] op;
        len = 4 + int'($urandom % 9);
        fill_halts();
        for (int i = 0; i < len; i++) begin
            case ($urandom % 3)
                0: op = OP_ADDI;
                1: op = OP_ADD;
                default: op = OP_SB;
            endcase
            prog[i] = encode_instr(op, 3'($urandom), 3'($urandom), 16'($urandom));
        end
    endtask

    task automatic model_clear();
        m_pc     = '0;
        m_halted = 1'b0;
        for (int i = 0; i < RB_REGS; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DM_BYTES; i++) begin
            m_dm[i] = '0;
        end
    endtask

    task automatic model_step();
        logic [31:0] ins;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [31:0] imm;
        ins = prog[m_pc[IM_ADDR_W-1:2]];
        rd  = ins[22:20];
        rs  = ins[18:16];
        rt  = ins[14:12];
        imm = {{16{ins[15]}}, ins[15:0]};
        if (!m_halted) begin
            case (ins[31:24])
                OP_ADDI: m_regs[rd] = m_regs[rs] + imm;
                OP_ADD:  m_regs[rd] = m_regs[rs] + m_regs[rt];
                OP_SB:   m_dm[ins[DM_ADDR_W-1:0]] = m_regs[rs][7:0];
                default: ;
            endcase
            if (ins[31:24] == OP_HALT) begin
                m_halted = 1'b1;
            end else begin
                m_pc = (m_pc + 32'd4) % IM_BYTES;
            end
        end
    endtask

    task automatic model_run_to_halt();
        for (int i = 0; i < IM_BYTES && !m_halted; i++) begin
            model_step();
        end
    endtask

    task automatic load_program();
        send_byte(CMD_WRITE_IM);
        for (int i = 0; i < IM_BYTES; i++) begin
            send_byte(prog[i / 4][8 * (3 - i % 4) +: 8]);  // Big-endian
        end
        model_clear();
    endtask

    task automatic read_pc_dump(input string name);
        logic [7:0]   value;
        core_status_t exp;
        core_status_t act;
        act.pc = '0;
        for (int i = 0; i < 4; i++) begin
            get_byte(name, value);
            act.pc = {act.pc[23:0], value};
        end
        act.halted = halted;
        exp.halted = m_halted;
        exp.pc     = m_pc;
        compare_status({name, " pc"}, exp, act);
    endtask

    task automatic read_mem_dump(input string name);
        logic [7:0] value;
        for (int i = 0; i < DM_BYTES; i++) begin
            get_byte(name, value);
            compare_byte($sformatf("%s dm[%0d]", name, i), m_dm[i], value);
        end
    endtask

    task automatic read_reg_dump(input string name);
        logic [7:0]  value;
        logic [31:0] word;
        for (int r = 0; r < RB_REGS; r++) begin
            word = '0;
            for (int i = 0; i < 4; i++) begin
                get_byte(name, value);
                word = {word[23:0], value};
            end
            compare_word($sformatf("%s r%0d", name, r), m_regs[r], word);
        end
    endtask

    task automatic dump_and_check(input string name);
        send_byte(CMD_SEND_MEM);
        read_mem_dump(name);
        send_byte(CMD_SEND_BR);
        read_reg_dump(name);
        send_byte(CMD_SEND_PC);
        read_pc_dump(name);
    endtask

    // One step reply: PC, data memory, registers
    task automatic step_and_check(input string name);
        send_byte(CMD_STEP);
        model_step();
        read_pc_dump(name);
        read_mem_dump(name);
        read_reg_dump(name);
    endtask

    task automatic check_reset_state();
        send_byte(CMD_SEND_PC);
        read_pc_dump("reset_state");
        send_byte(CMD_SEND_MEM);
        read_mem_dump("reset_state");
    endtask

    task automatic reject_bad_commands();
        send_byte(CMD_STEP);
        expect_silence("bad_commands step in idle");
        send_byte(CMD_START);
        expect_silence("bad_commands start before load");
        send_byte(8'h55);
        expect_silence("bad_commands unknown byte");
        send_byte(CMD_SEND_PC);
        read_pc_dump("bad_commands");
    endtask

    task automatic run_fixed_program();
        set_fixed_program();
        load_program();
        send_byte(CMD_START);
        wait_halted("fixed_run");
        model_run_to_halt();
        dump_and_check("fixed_run");
    endtask

    task automatic step_fixed_program();
        set_fixed_program();
        load_program();
        send_byte(CMD_STEP_BY_STEP);
        for (int s = 0; s < FIXED_LEN; s++) begin
            step_and_check($sformatf("fixed_step %0d", s));
        end
        send_byte(CMD_SEND_PC);  // Answered only back in IDLE
        read_pc_dump("fixed_step after halt");
    endtask

    task automatic step_then_continue();
        set_fixed_program();
        load_program();
        send_byte(CMD_STEP_BY_STEP);
        step_and_check("continue step 0");
        step_and_check("continue step 1");
        send_byte(CMD_CONTINUE);
        wait_halted("continue");
        model_run_to_halt();
        dump_and_check("continue");
    endtask

    // Each reload must start from a cleared core
    task automatic run_random_programs();
        for (int p = 0; p < 3; p++) begin
            set_random_program();
            load_program();
            send_byte(CMD_START);
            wait_halted($sformatf("random_program %0d", p));
            model_run_to_halt();
            dump_and_check($sformatf("random_program %0d", p));
        end
    endtask

    initial begin : main
        void'($urandom(SEED));
        monitor_on = 1'b0;
        rx_serial <= 1'b1;
        reset     <= 1'b1;
        model_clear();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        monitor_on = 1'b1;

        check_reset_state();
        reject_bad_commands();
        run_fixed_program();
        step_fixed_program();
        step_then_continue();
        run_random_programs();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== logic/debug_system.sv ====
`timescale 1ns/1ns

module debug_system import debug_pkg::*; (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx_serial,
    output logic o_tx_serial,
    output logic o_halted
);

    uart_byte_t           rx_byte;
    logic                 tx_start;
    logic [7:0]           tx_data;
    logic                 tx_done;
    im_write_t            im_write;
    core_ctrl_t           core_ctrl;
    core_status_t         status;
    logic [RB_ADDR_W-1:0] rb_addr;
    logic [DM_ADDR_W-1:0] dm_addr;
    logic [31:0]          rb_data;
    logic [7:0]           dm_data;

    uart_rx i_uart_rx (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx_serial (i_rx_serial),
        .o_rx        (rx_byte)
    );

    uart_tx i_uart_tx (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_tx_start  (tx_start),
        .i_tx_data   (tx_data),
        .o_tx_serial (o_tx_serial),
        .o_tx_done   (tx_done)
    );

    debug_unit i_debug_unit (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx        (rx_byte),
        .i_tx_done   (tx_done),
        .i_status    (status),
        .i_rb_data   (rb_data),
        .i_dm_data   (dm_data),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data),
        .o_im_write  (im_write),
        .o_core_ctrl (core_ctrl),
        .o_rb_addr   (rb_addr),
        .o_dm_addr   (dm_addr)
    );

    mini_core i_mini_core (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_im_write (im_write),
        .i_ctrl     (core_ctrl),
        .i_rb_addr  (rb_addr),
        .i_dm_addr  (dm_addr),
        .o_status   (status),
        .o_rb_data  (rb_data),
        .o_dm_data  (dm_data)
    );

    assign o_halted = status.halted;

endmodule

// ==== logic/mini_core.sv ====
`timescale 1ns/1ns

module mini_core import debug_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  im_write_t            i_im_write,
    input  core_ctrl_t           i_ctrl,
    input  logic [RB_ADDR_W-1:0] i_rb_addr,
    input  logic [DM_ADDR_W-1:0] i_dm_addr,
    output core_status_t         o_status,
    output logic [31:0]          o_rb_data,
    output logic [7:0]           o_dm_data
);

    logic [7:0]           imem [IM_BYTES];
    logic [7:0]           dmem [DM_BYTES];
    logic [31:0]          regs [RB_REGS];

    logic [IM_ADDR_W-1:0] pc;
    logic                 halted;
    logic                 exec;
    logic [31:0]          instr;
    core_op_e             op;
    logic [RB_ADDR_W-1:0] rd;
    logic [RB_ADDR_W-1:0] rs;
    logic [RB_ADDR_W-1:0] rt;
    logic [31:0]          imm_ext;

    // Loaded byte by byte from the debugger
    always_ff @(posedge i_clock) begin
        if (i_im_write.en) begin
            imem[i_im_write.addr] <= i_im_write.data;
        end
    end

    // Big-endian fetch
    assign instr = {imem[pc],
                    imem[pc + IM_ADDR_W'(1)],
                    imem[pc + IM_ADDR_W'(2)],
                    imem[pc + IM_ADDR_W'(3)]};

    assign op      = core_op_e'(instr[31:24]);
    assign rd      = instr[20 +: RB_ADDR_W];
    assign rs      = instr[16 +: RB_ADDR_W];
    assign rt      = instr[12 +: RB_ADDR_W];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};  // Sign extended

    assign exec = (i_ctrl.run || i_ctrl.step) && !halted;

    always_ff @(posedge i_clock) begin
        if (i_reset || i_ctrl.clear) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (exec) begin
            if (op == OP_HALT) begin
                halted <= 1'b1;  // PC stays on the halt
            end else begin
                pc <= pc + IM_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_ctrl.clear) begin
            for (int i = 0; i < RB_REGS; i++) begin
                regs[i] <= '0;
            end
            for (int i = 0; i < DM_BYTES; i++) begin
                dmem[i] <= '0;
            end
        end else if (exec) begin
            case (op)
                OP_ADDI: regs[rd] <= regs[rs] + imm_ext;
                OP_ADD:  regs[rd] <= regs[rs] + regs[rt];
                OP_SB:   dmem[instr[DM_ADDR_W-1:0]] <= regs[rs][7:0];
                default: ;  // NOP, HALT and unknown opcodes
            endcase
        end
    end

    // Debug read ports
    assign o_status.halted = halted;
    assign o_status.pc     = 32'(pc);
    assign o_rb_data       = regs[i_rb_addr];
    assign o_dm_data       = dmem[i_dm_addr];

endmodule

// ==== logic/debug_unit.sv ====
`timescale 1ns/1ns

module debug_unit import debug_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  uart_byte_t           i_rx,
    input  logic                 i_tx_done,
    input  core_status_t         i_status,
    input  logic [31:0]          i_rb_data,
    input  logic [7:0]           i_dm_data,
    output logic                 o_tx_start,
    output logic [7:0]           o_tx_data,
    output im_write_t            o_im_write,
    output core_ctrl_t           o_core_ctrl,
    output logic [RB_ADDR_W-1:0] o_rb_addr,
    output logic [DM_ADDR_W-1:0] o_dm_addr
);

    dbg_state_e           state;
    dbg_state_e           ret_state;  // IDLE ends a dump, STEP_BY_STEP chains it
    dbg_cmd_e             cmd;
    logic [IM_ADDR_W-1:0] load_cnt;
    logic [1:0]           byte_cnt;
    logic [DM_ADDR_W-1:0] dm_cnt;
    logic [RB_ADDR_W-1:0] rb_cnt;
    logic                 sending;
    logic [7:0]           tx_byte;

    // Byte idx of a word, most significant first
    function automatic logic [7:0] msb_byte(input logic [31:0] word, input logic [1:0] idx);
        logic [4:0] shift;
        shift = {~idx, 3'b000};
        return word[shift +: 8];
    endfunction

    assign cmd       = dbg_cmd_e'(i_rx.data);
    assign o_rb_addr = rb_cnt;
    assign o_dm_addr = dm_cnt;

    always_comb begin
        case (state)
            SEND_MEM: tx_byte = i_dm_data;
            SEND_BR:  tx_byte = msb_byte(i_rb_data, byte_cnt);
            default:  tx_byte = msb_byte(i_status.pc, byte_cnt);
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state         <= IDLE;
            ret_state     <= IDLE;
            load_cnt      <= '0;
            byte_cnt      <= '0;
            dm_cnt        <= '0;
            rb_cnt        <= '0;
            sending       <= 1'b0;
            o_tx_start    <= 1'b0;
            o_im_write.en <= 1'b0;
            o_core_ctrl   <= '0;
        end else begin
            // Single cycle pulses
            o_tx_start        <= 1'b0;
            o_im_write.en     <= 1'b0;
            o_core_ctrl.clear <= 1'b0;
            o_core_ctrl.step  <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_rx.strobe) begin
                        ret_state <= IDLE;
                        case (cmd)
                            CMD_WRITE_IM: begin
                                o_core_ctrl.clear <= 1'b1;
                                load_cnt          <= '0;
                                state             <= START_WRITE_IM;
                            end
                            CMD_SEND_PC:  state <= SEND_PC;
                            CMD_SEND_MEM: state <= SEND_MEM;
                            CMD_SEND_BR:  state <= SEND_BR;
                            default: ;
                        endcase
                    end
                end
                START_WRITE_IM: state <= WRITE_IM;  // Clear pulse lands here
                WRITE_IM: begin
                    if (i_rx.strobe) begin
                        o_im_write.en   <= 1'b1;
                        o_im_write.addr <= load_cnt;
                        o_im_write.data <= i_rx.data;
                        load_cnt        <= load_cnt + 1'b1;
                        if (load_cnt == IM_ADDR_W'(IM_BYTES - 1)) begin
                            state <= READY;
                        end
                    end
                end
                READY: begin
                    if (i_rx.strobe) begin
                        case (cmd)
                            CMD_START: begin
                                o_core_ctrl.run <= 1'b1;
                                state           <= START;
                            end
                            CMD_STEP_BY_STEP: state <= STEP_BY_STEP;
                            default: ;
                        endcase
                    end
                end
                START: begin
                    if (i_status.halted) begin
                        o_core_ctrl.run <= 1'b0;
                        state           <= IDLE;
                    end
                end
                STEP_BY_STEP: begin
                    if (i_rx.strobe) begin
                        case (cmd)
                            CMD_STEP: begin
                                o_core_ctrl.step <= 1'b1;
                                ret_state        <= STEP_BY_STEP;
                                state            <= SEND_PC;
                            end
                            CMD_CONTINUE: begin
                                o_core_ctrl.run <= 1'b1;
                                state           <= START;
                            end
                            default: ;
                        endcase
                    end
                end
                SEND_PC, SEND_MEM, SEND_BR: begin
                    // Hold the first byte until a pending step has executed
                    if (!sending && !o_core_ctrl.step) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= tx_byte;
                        sending    <= 1'b1;
                    end else if (sending && i_tx_done) begin
                        sending <= 1'b0;
                        case (state)
                            SEND_PC: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                if (byte_cnt == 2'd3) begin
                                    state <= (ret_state == STEP_BY_STEP) ? SEND_MEM : IDLE;
                                end
                            end
                            SEND_MEM: begin
                                dm_cnt <= dm_cnt + 1'b1;
                                if (dm_cnt == DM_ADDR_W'(DM_BYTES - 1)) begin
                                    dm_cnt <= '0;
                                    state  <= (ret_state == STEP_BY_STEP) ? SEND_BR : IDLE;
                                end
                            end
                            default: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                if (byte_cnt == 2'd3) begin
                                    rb_cnt <= rb_cnt + 1'b1;
                                    if (rb_cnt == RB_ADDR_W'(RB_REGS - 1)) begin
                                        rb_cnt <= '0;
                                        if (ret_state == STEP_BY_STEP && !i_status.halted) begin
                                            state <= STEP_BY_STEP;
                                        end else begin
                                            state <= IDLE;
                                        end
                                    end
                                end
                            end
                        endcase
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx import debug_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_tx_start,
    input  logic [7:0] i_tx_data,
    output logic       o_tx_serial,
    output logic       o_tx_done
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e            state;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_cnt;
    logic [7:0]           shift;
    logic                 bit_end;

    assign bit_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= TX_IDLE;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            o_tx_serial <= 1'b1;  // Line idles high
            o_tx_done   <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            clk_cnt   <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt     <= '0;
                    o_tx_serial <= 1'b1;
                    if (i_tx_start) begin
                        shift       <= i_tx_data;
                        o_tx_serial <= 1'b0;
                        state       <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_tx_serial <= shift[0];
                        bit_cnt     <= '0;
                        state       <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            o_tx_serial <= 1'b1;  // Stop bit
                            state       <= TX_STOP;
                        end else begin
                            shift       <= shift >> 1;
                            o_tx_serial <= shift[1];
                            bit_cnt     <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        o_tx_done <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx import debug_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_rx_serial,
    output uart_byte_t o_rx
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e              state;
    logic [1:0]             sync;
    logic                   rx_bit;
    logic [CLK_CNT_W-1:0]   clk_cnt;
    logic [2:0]             bit_cnt;
    logic [7:0]             shift;

    // Line is asynchronous to the core clock
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], i_rx_serial};
        end
    end

    assign rx_bit = sync[1];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            o_rx.strobe <= 1'b0;
        end else begin
            o_rx.strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_bit) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_bit ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        shift   <= {rx_bit, shift[7:1]};  // LSB arrives first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        o_rx.strobe <= 1'b1;
                        o_rx.data   <= shift;
                        state       <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/debug_pkg.sv ====
package debug_pkg;

    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

    localparam int IM_BYTES  = 64;  // 16 instructions
    localparam int DM_BYTES  = 16;
    localparam int RB_REGS   = 8;
    localparam int IM_ADDR_W = 6;
    localparam int DM_ADDR_W = 4;
    localparam int RB_ADDR_W = 3;

    typedef enum logic [3:0] {
        IDLE,
        START_WRITE_IM,
        WRITE_IM,
        READY,
        START,
        STEP_BY_STEP,
        SEND_PC,
        SEND_MEM,
        SEND_BR
    } dbg_state_e;

    // Host command bytes
    typedef enum logic [7:0] {
        CMD_WRITE_IM     = 8'd1,
        CMD_START        = 8'd2,
        CMD_STEP_BY_STEP = 8'd3,
        CMD_SEND_BR      = 8'd4,
        CMD_SEND_MEM     = 8'd5,
        CMD_SEND_PC      = 8'd6,
        CMD_STEP         = 8'd7,
        CMD_CONTINUE     = 8'd8
    } dbg_cmd_e;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADDI = 8'h01,
        OP_ADD  = 8'h02,
        OP_SB   = 8'h03,
        OP_HALT = 8'hff
    } core_op_e;

    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } uart_byte_t;

    typedef struct packed {
        logic                 en;
        logic [IM_ADDR_W-1:0] addr;
        logic [7:0]           data;
    } im_write_t;

    typedef struct packed {
        logic clear;
        logic run;
        logic step;
    } core_ctrl_t;

    typedef struct packed {
        logic        halted;
        logic [31:0] pc;
    } core_status_t;

endpackage
